//--- hw/conic_pkg.sv
// Conic renderer shared types
`default_nettype none

package conic_pkg;

    localparam int coord_w = 10;   // Covers 480x272 plus sign room on differences
    localparam int addr_w  = 8;    // AXI4-Lite byte address width

    // Register map, one 32-bit word each
    localparam logic [addr_w-1:0] addr_ctrl     = 8'h00;  // Shape enables
    localparam logic [addr_w-1:0] addr_ell_ctr  = 8'h04;
    localparam logic [addr_w-1:0] addr_ell_geom = 8'h08;
    localparam logic [addr_w-1:0] addr_par_vtx  = 8'h0C;
    localparam logic [addr_w-1:0] addr_par_geom = 8'h10;
    localparam logic [addr_w-1:0] addr_hyp_ctr  = 8'h14;
    localparam logic [addr_w-1:0] addr_hyp_geom = 8'h18;
    localparam logic [addr_w-1:0] addr_disp     = 8'h1C;  // Seven-segment word

    // Enable bits inside the control word
    localparam int en_ell_bit = 0;
    localparam int en_par_bit = 1;
    localparam int en_hyp_bit = 2;

    typedef struct packed {
        logic [coord_w-1:0] cx;
        logic [coord_w-1:0] cy;
    } point_t;

    // Semi-axes, ellipse and hyperbola reading
    typedef struct packed {
        logic [coord_w-1:0] ra;
        logic [coord_w-1:0] rb;
        logic [11:0]        pad;
    } axes_t;

    // Parabola reading of the same word
    typedef struct packed {
        logic [coord_w-1:0] p;         // Vertex to focus
        logic               opens_up;
        logic [20:0]        pad;
    } focus_t;

    typedef union packed {
        axes_t  axes;
        focus_t focus;
    } geom_u;

    typedef struct packed {
        logic   en;
        point_t pt;    // Centre, or vertex for the parabola
        geom_u  geom;
    } shape_cfg_t;

    typedef struct packed {
        shape_cfg_t ell;
        shape_cfg_t par;
        shape_cfg_t hyp;
    } scene_cfg_t;

    // RGB565 as the LCD takes it
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb_t;

    typedef struct packed {
        logic               valid;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } pixel_t;

endpackage

`default_nettype wire

//--- hw/conic_regs.sv
// Shape register file
// AXI4-Lite slave
`timescale 1ns/1ps
`default_nettype none

module conic_regs (
    input  logic                           clock,
    input  logic                           arst_n,

    input  logic [conic_pkg::addr_w-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,

    input  logic [conic_pkg::addr_w-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,

    output conic_pkg::scene_cfg_t          cfg,
    output logic [31:0]                    disp_word
);

    localparam int         n_regs      = 8;
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic {st_idle, st_resp} ch_state_t;

    ch_state_t   wr_state;
    ch_state_t   rd_state;
    logic [31:0] regs [n_regs];
    logic        wr_fire;
    logic        rd_fire;
    logic        wr_hit;
    logic        rd_hit;

    // Word aligned and inside the eight-word window
    function automatic logic is_mapped(input logic [conic_pkg::addr_w-1:0] a);
        is_mapped = (a < 4 * n_regs) && (a[1:0] == 2'b00);
    endfunction

    // AW and W taken together, only with no response pending
    assign awready = (wr_state == st_idle) && awvalid && wvalid;
    assign wready  = awready;
    assign wr_fire = awready;
    assign wr_hit  = is_mapped(awaddr);
    assign bvalid  = (wr_state == st_resp);

    assign arready = (rd_state == st_idle);
    assign rd_fire = arready && arvalid;
    assign rd_hit  = is_mapped(araddr);
    assign rvalid  = (rd_state == st_resp);

    // Write channel FSM
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= st_idle;
        end else begin
            case (wr_state)
                st_idle: if (wr_fire) wr_state <= st_resp;
                st_resp: if (bready)  wr_state <= st_idle;
                default: wr_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_fire) bresp <= wr_hit ? resp_okay : resp_slverr;
    end

    // Register file, byte lanes per wstrb
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr_fire && wr_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    regs[awaddr[4:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Read channel FSM
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= st_idle;
        end else begin
            case (rd_state)
                st_idle: if (rd_fire) rd_state <= st_resp;
                st_resp: if (rready)  rd_state <= st_idle;
                default: rd_state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire) begin
            rdata <= rd_hit ? regs[araddr[4:2]] : '0;  // Zero on a miss
            rresp <= rd_hit ? resp_okay : resp_slverr;
        end
    end

    // Unpack into shape configs
    assign cfg.ell.en   = regs[conic_pkg::addr_ctrl[4:2]][conic_pkg::en_ell_bit];
    assign cfg.par.en   = regs[conic_pkg::addr_ctrl[4:2]][conic_pkg::en_par_bit];
    assign cfg.hyp.en   = regs[conic_pkg::addr_ctrl[4:2]][conic_pkg::en_hyp_bit];
    assign cfg.ell.pt   = regs[conic_pkg::addr_ell_ctr[4:2]][19:0];
    assign cfg.ell.geom = regs[conic_pkg::addr_ell_geom[4:2]];
    assign cfg.par.pt   = regs[conic_pkg::addr_par_vtx[4:2]][19:0];
    assign cfg.par.geom = regs[conic_pkg::addr_par_geom[4:2]];
    assign cfg.hyp.pt   = regs[conic_pkg::addr_hyp_ctr[4:2]][19:0];
    assign cfg.hyp.geom = regs[conic_pkg::addr_hyp_geom[4:2]];
    assign disp_word    = regs[conic_pkg::addr_disp[4:2]];

    // Responses held until the master takes them
    a_bvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_rvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- hw/conic_shader.sv
// Conic pixel shader, three stages
`timescale 1ns/1ps
`default_nettype none

module conic_shader (
    input  logic                  clock,
    input  logic                  arst_n,
    input  conic_pkg::pixel_t     pix,
    input  conic_pkg::scene_cfg_t cfg,
    output conic_pkg::rgb_t       rgb,
    output logic                  rgb_valid
);

    localparam int cw = conic_pkg::coord_w;

    logic               s1_valid;
    logic signed [cw:0] s1_ex, s1_ey;   // Ellipse dx, dy
    logic signed [cw:0] s1_px, s1_py;   // Parabola dx, vy - y
    logic signed [cw:0] s1_hx, s1_hy;   // Hyperbola dx, dy

    logic            s2_valid;
    logic [2*cw-1:0] s2_sq_ex, s2_sq_ey;
    logic [2*cw-1:0] s2_sq_px;
    logic [2*cw-1:0] s2_sq_hx, s2_sq_hy;
    logic [2*cw-1:0] s2_ell_a2, s2_ell_b2;
    logic [2*cw-1:0] s2_hyp_a2, s2_hyp_b2;
    logic [2*cw+1:0] s2_par_lin;         // |vy - y| * 4p
    logic            s2_par_side;        // Pixel on the opening side

    logic [4*cw:0] ell_lhs, ell_rhs;
    logic [4*cw:0] hyp_lhs, hyp_rhs;
    logic          ell_hit, par_hit, hyp_hit;

    function automatic logic signed [cw:0] diff(input logic [cw-1:0] a,
                                                input logic [cw-1:0] b);
        diff = $signed({1'b0, a}) - $signed({1'b0, b});
    endfunction

    function automatic logic [cw-1:0] mag(input logic signed [cw:0] d);
        mag = d[cw] ? cw'(-d) : d[cw-1:0];
    endfunction

    function automatic logic [2*cw-1:0] sq(input logic [cw-1:0] m);
        sq = m * m;  // Operands widen to the result
    endfunction

    // Valid pipe, the only reset state here
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rgb_valid <= 1'b0;
        end else begin
            s1_valid  <= pix.valid;
            s2_valid  <= s1_valid;
            rgb_valid <= s2_valid;
        end
    end

    // Stage 1, signed differences
    always_ff @(posedge clock) begin
        s1_ex <= diff(pix.x, cfg.ell.pt.cx);
        s1_ey <= diff(pix.y, cfg.ell.pt.cy);
        s1_px <= diff(pix.x, cfg.par.pt.cx);
        s1_py <= diff(cfg.par.pt.cy, pix.y);  // Vertex minus pixel
        s1_hx <= diff(pix.x, cfg.hyp.pt.cx);
        s1_hy <= diff(pix.y, cfg.hyp.pt.cy);
    end

    // Stage 2, squares and the parabola linear term
    always_ff @(posedge clock) begin
        s2_sq_ex <= sq(mag(s1_ex));
        s2_sq_ey <= sq(mag(s1_ey));
        s2_sq_px <= sq(mag(s1_px));
        s2_sq_hx <= sq(mag(s1_hx));
        s2_sq_hy <= sq(mag(s1_hy));

        s2_ell_a2 <= sq(cfg.ell.geom.axes.ra);
        s2_ell_b2 <= sq(cfg.ell.geom.axes.rb);
        s2_hyp_a2 <= sq(cfg.hyp.geom.axes.ra);
        s2_hyp_b2 <= sq(cfg.hyp.geom.axes.rb);

        s2_par_lin <= mag(s1_py) * {cfg.par.geom.focus.p, 2'b00};
        // Up needs y <= vy, down needs y >= vy
        s2_par_side <= cfg.par.geom.focus.opens_up ? !s1_py[cw]
                                                   : (s1_py[cw] || s1_py == '0);
    end

    // Stage 3 weighted sums
    always_comb begin
        ell_lhs = s2_sq_ex * s2_ell_b2 + s2_sq_ey * s2_ell_a2;
        ell_rhs = s2_ell_a2 * s2_ell_b2;
        // dx2*b2 - dy2*a2 < a2*b2, moved to one side to stay unsigned
        hyp_lhs = s2_sq_hx * s2_hyp_b2;
        hyp_rhs = s2_hyp_a2 * s2_hyp_b2 + s2_sq_hy * s2_hyp_a2;

        ell_hit = cfg.ell.en && (ell_lhs <= ell_rhs);
        par_hit = cfg.par.en && s2_par_side && (s2_par_lin >= {2'b00, s2_sq_px});
        hyp_hit = cfg.hyp.en && (hyp_lhs < hyp_rhs);
    end

    // Colours add where shapes overlap
    always_ff @(posedge clock) begin
        rgb.red   <= ell_hit ? 5'd31 : 5'd0;
        rgb.green <= hyp_hit ? 6'd63 : 6'd0;
        rgb.blue  <= par_hit ? 5'd31 : 5'd0;
    end

    // Fixed three-cycle latency
    a_latency: assert property (@(posedge clock) disable iff (!arst_n)
        rgb_valid == $past(pix.valid, 3));

endmodule

`default_nettype wire

//--- hw/seg_scan_timer.sv
// Digit scan timer
`timescale 1ns/1ps
`default_nettype none

module seg_scan_timer #(
    parameter int w_digit    = 8,
    parameter int scan_div_w = 16
) (
    input  logic                       clock,
    input  logic                       arst_n,
    output logic [$clog2(w_digit)-1:0] digit_index
);

    logic [scan_div_w-1:0] presc;   // Free running
    logic                  tick;

    assign tick = &presc;  // Once per 2^scan_div_w cycles

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            digit_index <= '0;
        end else if (tick) begin
            if (digit_index == w_digit - 1) digit_index <= '0;  // Wrap
            else                            digit_index <= digit_index + 1'b1;
        end
    end

    a_index_range: assert property (@(posedge clock) disable iff (!arst_n)
        digit_index < w_digit);

endmodule

`default_nettype wire

//--- hw/seven_segment_display.sv
// Hex seven-segment decoder
`timescale 1ns/1ps
`default_nettype none

module seven_segment_display #(
    parameter int w_digit = 8
) (
    input  logic [$clog2(w_digit)-1:0] digit_index,
    input  logic [31:0]                number,
    output logic [7:0]                 abcdefgh,
    output logic [w_digit-1:0]         digit
);

    logic [3:0] nibble;
    logic [6:0] seg;     // a..g, a is the MSB

    assign nibble = number[4*digit_index +: 4];  // Digit i shows nibble i

    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1111110;
            4'h1: seg = 7'b0110000;
            4'h2: seg = 7'b1101101;
            4'h3: seg = 7'b1111001;
            4'h4: seg = 7'b0110011;
            4'h5: seg = 7'b1011011;
            4'h6: seg = 7'b1011111;
            4'h7: seg = 7'b1110000;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1111011;
            4'ha: seg = 7'b1110111;
            4'hb: seg = 7'b0011111;  // Lower case b
            4'hc: seg = 7'b1001110;
            4'hd: seg = 7'b0111101;  // Lower case d
            4'he: seg = 7'b1001111;
            default: seg = 7'b1000111;  // F
        endcase
    end

    assign abcdefgh = {seg, 1'b0};  // Dot off

    // One-hot enable, active high
    assign digit = w_digit'(1) << digit_index;

endmodule

`default_nettype wire

//--- hw/conic_scene_top.sv
// Conic scene renderer top
`timescale 1ns/1ps
`default_nettype none

module conic_scene_top #(
    parameter int w_digit    = 8,
    parameter int scan_div_w = 16
) (
    input  logic                           clock,
    input  logic                           arst_n,

    // AXI4-Lite register port
    input  logic [conic_pkg::addr_w-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [conic_pkg::addr_w-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,

    // Pixel stream, no back-pressure
    input  conic_pkg::pixel_t              pix,
    output conic_pkg::rgb_t                rgb,
    output logic                           rgb_valid,

    output logic [7:0]                     abcdefgh,
    output logic [w_digit-1:0]             digit
);

    conic_pkg::scene_cfg_t       cfg;
    logic [31:0]                 disp_word;
    logic [$clog2(w_digit)-1:0]  digit_index;

    conic_regs u_conic_regs (
        .clock   (clock),   .arst_n  (arst_n),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wstrb   (wstrb),   .wvalid  (wvalid),   .wready (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),   .rready (rready),
        .cfg     (cfg),     .disp_word (disp_word)
    );

    conic_shader u_conic_shader (
        .clock     (clock),
        .arst_n    (arst_n),
        .pix       (pix),
        .cfg       (cfg),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

    seg_scan_timer #(.w_digit (w_digit), .scan_div_w (scan_div_w)) u_seg_scan_timer (
        .clock       (clock),
        .arst_n      (arst_n),
        .digit_index (digit_index)
    );

    seven_segment_display #(.w_digit (w_digit)) u_seven_segment_display (
        .digit_index (digit_index),
        .number      (disp_word),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

endmodule

`default_nettype wire

//--- tests/tb_axil_tasks.svh
// AXI4-Lite master tasks
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// AW and W presented together, B taken one cycle late
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
    int n;
    @(negedge clock);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (n = 0; n < 20 && !bvalid; n++) @(negedge clock);
    if (!bvalid) begin
        $display("Write to address %h got no response", addr);
        fail_count++;
    end
    resp    = bresp;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;   // Taken on the next rising edge
    @(negedge clock);
    bready  = 1'b0;
    // Mapped words update the expected copy byte by byte
    if (addr < 8'h20 && addr[1:0] == 2'b00) begin
        for (n = 0; n < 4; n++) begin
            if (strb[n]) shadow[addr[4:2]][8*n +: 8] = data[8*n +: 8];
        end
    end
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int n;
    @(negedge clock);
    araddr  = addr;
    arvalid = 1'b1;
    for (n = 0; n < 20 && !rvalid; n++) @(negedge clock);
    if (!rvalid) begin
        $display("Read from address %h got no response", addr);
        fail_count++;
    end
    data    = rdata;
    resp    = rresp;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge clock);
    rready  = 1'b0;
endtask

`endif

//--- tests/tb_conic_scene.sv
// Conic scene renderer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_conic_scene;

    localparam int w_digit    = 8;
    localparam int scan_div_w = 3;      // Fast digit scan
    // Cycles for reset, registers, three shapes, orientation and display
    localparam int test_cycles = 200 + 250 + 3 * 350 + 2 * 350 + 300;
    localparam int clk_ns      = 8;
    localparam int watchdog_ns = test_cycles * clk_ns * 3 / 2;

    logic                         clock = 1'b0;
    logic                         arst_n;
    logic [conic_pkg::addr_w-1:0] awaddr;
    logic [conic_pkg::addr_w-1:0] araddr;
    logic                         awvalid, wvalid, bready, arvalid, rready;
    logic [31:0]                  wdata;
    logic [3:0]                   wstrb;
    logic                         awready, wready, bvalid, arready, rvalid;
    logic [1:0]                   bresp, rresp;
    logic [31:0]                  rdata;
    conic_pkg::pixel_t            pix;
    conic_pkg::rgb_t              rgb;
    logic                         rgb_valid;
    logic [7:0]                   abcdefgh;
    logic [w_digit-1:0]           digit;

    integer                 seed = 32'h4fea_71c7;
    int                     fail_count = 0;
    int                     fails_at_start = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    logic [31:0]            shadow [8];          // Expected register contents
    logic [2:0]             exp_vld;             // Model pipeline three deep
    conic_pkg::rgb_t [2:0]  exp_rgb;
    logic                   disp_check = 1'b0;
    logic [w_digit-1:0]     digits_seen;
    logic [7:0]             seg_expected;

    always #(clk_ns / 2) clock = ~clock;

    conic_scene_top #(.w_digit (w_digit), .scan_div_w (scan_div_w)) u_conic_scene_top (
        .clock (clock), .arst_n (arst_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .pix (pix), .rgb (rgb), .rgb_valid (rgb_valid),
        .abcdefgh (abcdefgh), .digit (digit)
    );

    `include "tb_axil_tasks.svh"

    function automatic logic [31:0] point_word(input int cx, input int cy);
        point_word = {12'd0, 10'(cx), 10'(cy)};
    endfunction

    function automatic logic [31:0] axes_word(input int ra, input int rb);
        axes_word = {10'(ra), 10'(rb), 12'd0};
    endfunction

    function automatic logic [31:0] focus_word(input int p, input logic up);
        focus_word = {10'(p), up, 21'd0};
    endfunction

    // Colour rule on the expected configuration
    function automatic conic_pkg::rgb_t colour_of(input int x, input int y);
        conic_pkg::rgb_t   c;
        conic_pkg::point_t pt;
        conic_pkg::geom_u  g;
        longint            dx, dy, a2, b2, lin;
        c = '0;
        if (shadow[0][conic_pkg::en_ell_bit]) begin
            pt = shadow[1][19:0];
            g  = shadow[2];
            dx = longint'(x) - longint'(pt.cx);
            dy = longint'(y) - longint'(pt.cy);
            a2 = longint'(g.axes.ra) * longint'(g.axes.ra);
            b2 = longint'(g.axes.rb) * longint'(g.axes.rb);
            if (dx * dx * b2 + dy * dy * a2 <= a2 * b2) c.red = 5'd31;
        end
        if (shadow[0][conic_pkg::en_par_bit]) begin
            pt  = shadow[3][19:0];
            g   = shadow[4];
            dx  = longint'(x) - longint'(pt.cx);
            dy  = longint'(pt.cy) - longint'(y);        // vy - y
            if (!g.focus.opens_up) dy = -dy;          // Mirror about the vertex
            lin = dy * 4 * longint'(g.focus.p);
            if (dy >= 0 && lin >= dx * dx) c.blue = 5'd31;
        end
        if (shadow[0][conic_pkg::en_hyp_bit]) begin
            pt = shadow[5][19:0];
            g  = shadow[6];
            dx = longint'(x) - longint'(pt.cx);
            dy = longint'(y) - longint'(pt.cy);
            a2 = longint'(g.axes.ra) * longint'(g.axes.ra);
            b2 = longint'(g.axes.rb) * longint'(g.axes.rb);
            if (dx * dx * b2 - dy * dy * a2 < a2 * b2) c.green = 6'd63;
        end
        return c;
    endfunction

    // Hex digit as a..g plus dark dot
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        logic [6:0] s;
        case (nib)
            4'h0: s = 7'b1111110;
            4'h1: s = 7'b0110000;
            4'h2: s = 7'b1101101;
            4'h3: s = 7'b1111001;
            4'h4: s = 7'b0110011;
            4'h5: s = 7'b1011011;
            4'h6: s = 7'b1011111;
            4'h7: s = 7'b1110000;
            4'h8: s = 7'b1111111;
            4'h9: s = 7'b1111011;
            4'ha: s = 7'b1110111;
            4'hb: s = 7'b0011111;
            4'hc: s = 7'b1001110;
            4'hd: s = 7'b0111101;
            4'he: s = 7'b1001111;
            default: s = 7'b1000111;
        endcase
        return {s, 1'b0};
    endfunction

    function automatic int digit_pos(input logic [w_digit-1:0] d);
        int pos;
        pos = 0;
        for (int i = 0; i < w_digit; i++) begin
            if (d[i]) pos = i;
        end
        return pos;
    endfunction

    assign seg_expected = seg_pattern(shadow[7][4*digit_pos(digit) +: 4]);

    // Model runs beside the shader with the same depth
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            exp_vld <= '0;
            exp_rgb <= '0;
        end else begin
            exp_vld <= {exp_vld[1:0], pix.valid};
            exp_rgb <= {exp_rgb[1:0], colour_of(pix.x, pix.y)};
        end
    end

    always @(posedge clock) begin
        if (!disp_check) digits_seen <= '0;
        else             digits_seen <= digits_seen | digit;
    end

    a_rgb_valid: assert property (@(posedge clock) disable iff (!arst_n)
        rgb_valid == exp_vld[2])
        else begin
            $display("CHECK FAILED t=%0t rgb_valid expected %b got %b",
                     $time, $sampled(exp_vld[2]), $sampled(rgb_valid));
            fail_count++;
        end

    a_rgb_value: assert property (@(posedge clock) disable iff (!arst_n)
        exp_vld[2] |-> rgb == exp_rgb[2])
        else begin
            $display("CHECK FAILED t=%0t rgb expected %h got %h",
                     $time, $sampled(exp_rgb[2]), $sampled(rgb));
            fail_count++;
        end

    // AW and W only together, with both valids up and no response pending
    a_write_accept: assert property (@(posedge clock) disable iff (!arst_n)
        (awready || wready) |-> (awready && wready && awvalid && wvalid && !bvalid))
        else begin
            $display("Write channel ready out of turn at t=%0t, awready %b wready %b bvalid %b",
                     $time, $sampled(awready), $sampled(wready), $sampled(bvalid));
            fail_count++;
        end

    // No new read address while a read response is held
    a_read_accept: assert property (@(posedge clock) disable iff (!arst_n)
        rvalid |-> !arready)
        else begin
            $display("Read address accepted during a pending response at t=%0t", $time);
            fail_count++;
        end

    a_digit_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot(digit))
        else begin
            $display("Digit enable is not one-hot at t=%0t: %b", $time, $sampled(digit));
            fail_count++;
        end

    a_segments: assert property (@(posedge clock) disable iff (!arst_n)
        disp_check |-> abcdefgh == seg_expected)
        else begin
            $display("CHECK FAILED t=%0t abcdefgh expected %b got %b",
                     $time, $sampled(seg_expected), $sampled(abcdefgh));
            fail_count++;
        end

    task automatic expect_word(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
            fail_count++;
        end
    endtask

    task automatic start_test();
        fails_at_start = fail_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (fail_count > fails_at_start) begin
            tests_failed++;
            $display("%-20s failed, %0d errors", name, fail_count - fails_at_start);
        end else begin
            $display("%-20s ok", name);
        end
    endtask

    // Random pixels with about one idle slot in four
    task automatic send_pixels(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clock);
            pix.x     = 10'($unsigned($random(seed)) % 480);
            pix.y     = 10'($unsigned($random(seed)) % 272);
            pix.valid = ($random(seed) & 3) != 0;
            if (pix.valid) sent++;
        end
        @(negedge clock);
        pix.valid = 1'b0;
        repeat (4) @(negedge clock);  // Drain the three stages
    endtask

    task automatic set_enables(input logic [2:0] en);
        logic [1:0] resp;
        write_reg(conic_pkg::addr_ctrl, {29'd0, en}, 4'hf, resp);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: tests still running after %0d ns", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        arst_n  = 1'b0;
        awaddr  = '0;
        araddr  = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = 1'b0;
        rready  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        pix     = '0;
        for (int i = 0; i < 8; i++) shadow[i] = '0;
        repeat (3) @(negedge clock);
        arst_n = 1'b1;

        start_test();
        expect_word("bvalid", 0, bvalid);
        expect_word("rvalid", 0, rvalid);
        expect_word("rgb_valid", 0, rgb_valid);
        expect_word("digit", 1, digit);           // Index starts at 0
        send_pixels(100);                          // All enables off so black
        finish_test("reset state");

        start_test();
        for (int i = 0; i < 8; i++) begin
            write_reg(8'(4 * i), 32'h5a3c_0f00 ^ (i * 32'h0111_1111), 4'hf, resp);
            expect_word("bresp", 2'b00, resp);
        end
        write_reg(conic_pkg::addr_disp, 32'hffff_ffff, 4'b0101, resp);  // Bytes 0 and 2
        for (int i = 0; i < 8; i++) begin
            read_reg(8'(4 * i), data, resp);
            expect_word("rdata", shadow[i], data);
            expect_word("rresp", 2'b00, resp);
        end
        write_reg(8'h20, 32'hdead_beef, 4'hf, resp);
        expect_word("bresp", 2'b10, resp);
        read_reg(8'h20, data, resp);
        expect_word("rdata", 0, data);
        expect_word("rresp", 2'b10, resp);
        read_reg(conic_pkg::addr_ctrl, data, resp);  // Word 0 untouched by the miss
        expect_word("rdata", shadow[0], data);
        finish_test("register access");

        // Ellipse and hyperbola mid screen with the parabola above a low vertex
        write_reg(conic_pkg::addr_ell_ctr, point_word(240, 136), 4'hf, resp);
        write_reg(conic_pkg::addr_ell_geom, axes_word(100, 60), 4'hf, resp);
        write_reg(conic_pkg::addr_par_vtx, point_word(240, 220), 4'hf, resp);
        write_reg(conic_pkg::addr_par_geom, focus_word(15, 1'b1), 4'hf, resp);
        write_reg(conic_pkg::addr_hyp_ctr, point_word(240, 136), 4'hf, resp);
        write_reg(conic_pkg::addr_hyp_geom, axes_word(50, 40), 4'hf, resp);

        start_test();
        set_enables(3'b001);
        send_pixels(200);
        finish_test("ellipse alone");
        start_test();
        set_enables(3'b010);
        send_pixels(200);
        finish_test("parabola alone");
        start_test();
        set_enables(3'b100);
        send_pixels(200);
        finish_test("hyperbola alone");

        start_test();
        write_reg(conic_pkg::addr_par_geom, focus_word(15, 1'b0), 4'hf, resp);
        set_enables(3'b010);
        send_pixels(200);
        set_enables(3'b111);                       // Overlaps add colours
        send_pixels(200);
        finish_test("parabola downward");

        start_test();
        write_reg(conic_pkg::addr_disp, 32'h1234_abcd, 4'hf, resp);
        disp_check = 1'b1;
        for (int n = 0; n < ((2 * w_digit) << scan_div_w) && digits_seen != '1; n++) begin
            @(negedge clock);
        end
        assert (digits_seen == '1) else begin
            $display("Display did not step through all eight digits, saw %b", digits_seen);
            fail_count++;
        end
        disp_check = 1'b0;
        finish_test("display scan");

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- conic_scene_top.f
+incdir+tests
hw/conic_pkg.sv
hw/conic_regs.sv
hw/conic_shader.sv
hw/seg_scan_timer.sv
hw/seven_segment_display.sv
hw/conic_scene_top.sv
tests/tb_conic_scene.sv

//--- Makefile
TOP = tb_conic_scene

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f conic_scene_top.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
